// File: Bender.yml
package:
  name: correlator

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/corr_pkg.sv
      - logic/slot_sequencer.sv
      - logic/sigsource.sv
      - logic/baseline_correlator.sv
      - logic/correlator_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/correlator_assertions.sv
      - tests/correlator_tb.sv

// File: logic/baseline_correlator.sv
`timescale 1ns/10ps
`include "corr_consts.svh"

// Per-slot accumulation of A*conj(B), dumped every ACC_FRAMES frames
module baseline_correlator (
  input  logic            clock,
  input  logic            reset_n,
  input  logic            valid_i,
  input  logic            first_i,
  input  logic            last_i,
  input  logic            ai_i,
  input  logic            aq_i,
  input  logic            bi_i,
  input  logic            bq_i,
  output logic            vis_valid_o,
  output corr_pkg::slot_t vis_slot_o,
  output corr_pkg::vis_t  vis_re_o,
  output corr_pkg::vis_t  vis_im_o
);
  import corr_pkg::*;

  localparam int TRATE      = `CORR_TRATE;
  localparam int ACC_FRAMES = `CORR_ACC_FRAMES;

  localparam slot_t      LAST_SLOT  = slot_t'(TRATE - 1);
  localparam frame_cnt_t LAST_FRAME = frame_cnt_t'(ACC_FRAMES - 1);

  vis_t        prod_re;     // -2, 0 or +2
  vis_t        prod_im;
  slot_t       slot_cnt;    // Expected slot of the next beat
  slot_t       beat_slot;   // Slot of the current beat
  frame_cnt_t  frame_cnt;
  logic        snapshot;    // Last beat of the integration
  dump_state_t state;
  slot_t       dump_slot;

  vis_t acc_re  [TRATE];
  vis_t acc_im  [TRATE];
  vis_t dump_re [TRATE];
  vis_t dump_im [TRATE];

  // Sign bit to +1 or -1
  function automatic vis_t sgn(input logic b);
    return b ? vis_t'(1) : vis_t'(-1);
  endfunction

  // Product of two signs is +1 when the bits agree
  assign prod_re = sgn(ai_i ~^ bi_i) + sgn(aq_i ~^ bq_i);
  assign prod_im = sgn(aq_i ~^ bi_i) - sgn(ai_i ~^ bq_i);

  assign beat_slot = first_i ? '0 : slot_cnt;  // first_i resyncs the count
  assign snapshot  = valid_i && last_i && (frame_cnt == LAST_FRAME);

  // Slot and frame counters
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      slot_cnt  <= '0;
      frame_cnt <= '0;
    end else if (valid_i) begin
      slot_cnt <= beat_slot + 1'b1;
      if (last_i) begin
        frame_cnt <= (frame_cnt == LAST_FRAME) ? '0 : frame_cnt + 1'b1;
      end
    end
  end

  // Accumulators, cleared at the snapshot
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      for (int k = 0; k < TRATE; k++) begin
        acc_re[k] <= '0;
        acc_im[k] <= '0;
      end
    end else if (valid_i) begin
      for (int k = 0; k < TRATE; k++) begin
        if (snapshot) begin
          acc_re[k] <= '0;
          acc_im[k] <= '0;
        end else if (slot_t'(k) == beat_slot) begin
          acc_re[k] <= acc_re[k] + prod_re;
          acc_im[k] <= acc_im[k] + prod_im;
        end
      end
    end
  end

  // Dump buffer, totals include the closing beat
  always_ff @(posedge clock) begin
    if (snapshot) begin
      for (int k = 0; k < TRATE; k++) begin
        dump_re[k] <= acc_re[k] + ((slot_t'(k) == beat_slot) ? prod_re : vis_t'(0));
        dump_im[k] <= acc_im[k] + ((slot_t'(k) == beat_slot) ? prod_im : vis_t'(0));
      end
    end
  end

  // Dump FSM, one slot per cycle
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state       <= ACCUM;
      dump_slot   <= '0;
      vis_valid_o <= 1'b0;
      vis_slot_o  <= '0;
    end else begin
      vis_valid_o <= (state == DUMP);  // Output register adds a cycle
      vis_slot_o  <= dump_slot;
      case (state)
        ACCUM: begin
          if (snapshot) begin
            state     <= DUMP;
            dump_slot <= '0;
          end
        end
        DUMP: begin
          if (dump_slot == LAST_SLOT) begin
            state     <= ACCUM;
            dump_slot <= '0;
          end else begin
            dump_slot <= dump_slot + 1'b1;
          end
        end
        default: state <= ACCUM;
      endcase
    end
  end

  // Visibility payload, qualified by vis_valid_o
  always_ff @(posedge clock) begin
    vis_re_o <= dump_re[dump_slot];
    vis_im_o <= dump_im[dump_slot];
  end

endmodule

// File: logic/corr_consts.svh
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// Array geometry
`define CORR_WIDTH 8
// Time-slots swept per held sample
`define CORR_TRATE 6
// Tapped antennas feeding each of the A and B MUXes
`define CORR_MUX_N 4

// Tap tables, 3-bit antenna index per MUX input, input 0 in the LSBs
`define CORR_ATAPS {3'd3, 3'd2, 3'd1, 3'd0}
`define CORR_BTAPS {3'd7, 3'd6, 3'd5, 3'd4}

// Per-slot MUX selects, slot 0 in the LSBs
// Pairs per slot are (0,4) (0,5) (1,5) (1,6) (2,7) (3,7)
`define CORR_ASELS {2'd3, 2'd2, 2'd1, 2'd1, 2'd0, 2'd0}
`define CORR_BSELS {2'd3, 2'd3, 2'd2, 2'd1, 2'd1, 2'd0}

// Integration length and accumulator size
`define CORR_ACC_FRAMES 4
`define CORR_ACC_BITS 8

`endif

// File: logic/corr_pkg.sv
`include "corr_consts.svh"

package corr_pkg;

  // One sign bit per antenna, bit 1 is +1 and bit 0 is -1
  typedef logic [`CORR_WIDTH-1:0] antenna_t;

  // Time-slot address within a frame
  typedef logic [$clog2(`CORR_TRATE)-1:0] slot_t;

  // Signed visibility component, also the accumulator type
  typedef logic signed [`CORR_ACC_BITS-1:0] vis_t;

  // Frames seen within the current integration
  typedef logic [$clog2(`CORR_ACC_FRAMES)-1:0] frame_cnt_t;

  // Sequencer FSM
  typedef enum logic {IDLE, SWEEP} seq_state_t;

  // Correlator dump FSM
  typedef enum logic {ACCUM, DUMP} dump_state_t;

endpackage

// File: logic/correlator_top.sv
`timescale 1ns/10ps

// Sequencer, sigsource and baseline correlator in a chain
module correlator_top (
  input  logic               clock,
  input  logic               reset_n,
  input  logic               sample_valid_i,
  input  corr_pkg::antenna_t sample_i_i,
  input  corr_pkg::antenna_t sample_q_i,
  output logic               vis_valid_o,
  output corr_pkg::slot_t    vis_slot_o,
  output corr_pkg::vis_t     vis_re_o,
  output corr_pkg::vis_t     vis_im_o
);
  import corr_pkg::*;

  // Sequencer to sigsource
  logic     seq_valid;
  logic     seq_first;
  logic     seq_last;
  slot_t    seq_taddr;
  antenna_t seq_idata;
  antenna_t seq_qdata;

  // Sigsource to correlator
  logic src_valid;
  logic src_first;
  logic src_last;
  logic src_ai;
  logic src_aq;
  logic src_bi;
  logic src_bq;

  slot_sequencer u_seq (
    .clock          (clock),
    .reset_n        (reset_n),
    .sample_valid_i (sample_valid_i),
    .sample_i_i     (sample_i_i),
    .sample_q_i     (sample_q_i),
    .valid_o        (seq_valid),
    .first_o        (seq_first),
    .last_o         (seq_last),
    .taddr_o        (seq_taddr),
    .idata_o        (seq_idata),
    .qdata_o        (seq_qdata)
  );

  // Tables from the defaults
  sigsource u_src (
    .clock   (clock),
    .reset_n (reset_n),
    .valid_i (seq_valid),
    .first_i (seq_first),
    .last_i  (seq_last),
    .taddr_i (seq_taddr),
    .idata_i (seq_idata),
    .qdata_i (seq_qdata),
    .valid_o (src_valid),
    .first_o (src_first),
    .last_o  (src_last),
    .ai_o    (src_ai),
    .aq_o    (src_aq),
    .bi_o    (src_bi),
    .bq_o    (src_bq)
  );

  baseline_correlator u_corr (
    .clock       (clock),
    .reset_n     (reset_n),
    .valid_i     (src_valid),
    .first_i     (src_first),
    .last_i      (src_last),
    .ai_i        (src_ai),
    .aq_i        (src_aq),
    .bi_i        (src_bi),
    .bq_i        (src_bq),
    .vis_valid_o (vis_valid_o),
    .vis_slot_o  (vis_slot_o),
    .vis_re_o    (vis_re_o),
    .vis_im_o    (vis_im_o)
  );

endmodule

// File: logic/sigsource.sv
`timescale 1ns/10ps
`include "corr_consts.svh"

// Picks the A and B antenna IQ bits for each slot
// Two pipeline stages, markers delayed to match
module sigsource #(
  parameter int WIDTH = `CORR_WIDTH,  // Antennas
  parameter int MUX_N = `CORR_MUX_N,  // Inputs per MUX
  parameter int TRATE = `CORR_TRATE,  // Slots per frame
  parameter logic [$clog2(WIDTH)*MUX_N-1:0] ATAPS = `CORR_ATAPS,
  parameter logic [$clog2(WIDTH)*MUX_N-1:0] BTAPS = `CORR_BTAPS,
  parameter logic [$clog2(MUX_N)*TRATE-1:0] ASELS = `CORR_ASELS,
  parameter logic [$clog2(MUX_N)*TRATE-1:0] BSELS = `CORR_BSELS
) (
  input  logic               clock,
  input  logic               reset_n,
  input  logic               valid_i,
  input  logic               first_i,
  input  logic               last_i,
  input  corr_pkg::slot_t    taddr_i,
  input  corr_pkg::antenna_t idata_i,
  input  corr_pkg::antenna_t qdata_i,
  output logic               valid_o,
  output logic               first_o,
  output logic               last_o,
  output logic               ai_o,
  output logic               aq_o,
  output logic               bi_o,
  output logic               bq_o
);

  localparam int SBITS = $clog2(WIDTH);  // Antenna index width
  localparam int XBITS = $clog2(MUX_N);  // MUX select width

  // Slot to select ROMs, unpacked from the tables
  logic [XBITS-1:0] a_sel_rom [TRATE];
  logic [XBITS-1:0] b_sel_rom [TRATE];

  logic [XBITS-1:0] asel;
  logic [XBITS-1:0] bsel;

  // Tapped antenna bits, one per MUX input
  logic [MUX_N-1:0] ai_src;
  logic [MUX_N-1:0] aq_src;
  logic [MUX_N-1:0] bi_src;
  logic [MUX_N-1:0] bq_src;

  logic valid_s1;
  logic first_s1;
  logic last_s1;

  for (genvar t = 0; t < TRATE; t++) begin : g_sel_rom
    assign a_sel_rom[t] = ASELS[t*XBITS +: XBITS];
    assign b_sel_rom[t] = BSELS[t*XBITS +: XBITS];
  end

  // Stage one, selects and taps
  always_ff @(posedge clock) begin
    asel <= a_sel_rom[taddr_i];
    bsel <= b_sel_rom[taddr_i];
    for (int m = 0; m < MUX_N; m++) begin
      ai_src[m] <= idata_i[ATAPS[m*SBITS +: SBITS]];
      aq_src[m] <= qdata_i[ATAPS[m*SBITS +: SBITS]];
      bi_src[m] <= idata_i[BTAPS[m*SBITS +: SBITS]];
      bq_src[m] <= qdata_i[BTAPS[m*SBITS +: SBITS]];
    end
  end

  // Marker pipeline, both stages
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      valid_s1 <= 1'b0;
      first_s1 <= 1'b0;
      last_s1  <= 1'b0;
      valid_o  <= 1'b0;
      first_o  <= 1'b0;
      last_o   <= 1'b0;
    end else begin
      valid_s1 <= valid_i;
      first_s1 <= first_i;
      last_s1  <= last_i;
      valid_o  <= valid_s1;
      first_o  <= first_s1;
      last_o   <= last_s1;
    end
  end

  // Stage two, the A and B MUXes
  always_ff @(posedge clock) begin
    ai_o <= ai_src[asel];
    aq_o <= aq_src[asel];
    bi_o <= bi_src[bsel];
    bq_o <= bq_src[bsel];
  end

endmodule

// File: logic/slot_sequencer.sv
`timescale 1ns/10ps
`include "corr_consts.svh"

// Holds one antenna sample and replays it over TRATE consecutive slots
module slot_sequencer (
  input  logic               clock,
  input  logic               reset_n,
  input  logic               sample_valid_i,  // One-cycle strobe
  input  corr_pkg::antenna_t sample_i_i,
  input  corr_pkg::antenna_t sample_q_i,
  output logic               valid_o,
  output logic               first_o,         // Slot 0 marker
  output logic               last_o,          // Slot TRATE-1 marker
  output corr_pkg::slot_t    taddr_o,
  output corr_pkg::antenna_t idata_o,
  output corr_pkg::antenna_t qdata_o
);
  import corr_pkg::*;

  localparam slot_t LAST_SLOT = slot_t'(`CORR_TRATE - 1);

  seq_state_t state;
  slot_t      slot_cnt;  // Stays at 0 while idle
  antenna_t   hold_i;
  antenna_t   hold_q;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state    <= IDLE;
      slot_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (sample_valid_i) begin
            state    <= SWEEP;  // First slot on the next cycle
            slot_cnt <= '0;
          end
        end
        SWEEP: begin
          // Strobes during a sweep are dropped
          if (slot_cnt == LAST_SLOT) begin
            state    <= IDLE;
            slot_cnt <= '0;
          end else begin
            slot_cnt <= slot_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Sample capture, only when a new sweep is accepted
  always_ff @(posedge clock) begin
    if (state == IDLE && sample_valid_i) begin
      hold_i <= sample_i_i;
      hold_q <= sample_q_i;
    end
  end

  assign valid_o = (state == SWEEP);
  assign first_o = valid_o && (slot_cnt == '0);
  assign last_o  = valid_o && (slot_cnt == LAST_SLOT);
  assign taddr_o = slot_cnt;
  assign idata_o = hold_i;   // Same sample on every slot
  assign qdata_o = hold_q;

endmodule

// File: tests/correlator_assertions.sv
`timescale 1ns/10ps
`include "corr_consts.svh"

// Protocol checks on the sample input, the frame markers and the dump
module correlator_assertions (
  input logic            clock,
  input logic            reset_n,
  input logic            sample_valid_i,
  input logic            seq_valid_i,
  input logic            seq_first_i,
  input logic            seq_last_i,
  input logic            vis_valid_i,
  input corr_pkg::slot_t vis_slot_i
);
  import corr_pkg::*;

  localparam slot_t LAST_SLOT = slot_t'(`CORR_TRATE - 1);

  int fail_cnt = 0;  // Failed assertions so far

  // No new strobe while the sequencer sweeps
  a_sample_gap: assert property (@(posedge clock) disable iff (!reset_n)
    sample_valid_i |=> !sample_valid_i [*`CORR_TRATE])
    else begin
      $error("sample strobes closer than TRATE+1 cycles");
      fail_cnt++;
    end

  // A frame spans TRATE beats from first to last
  a_frame_len: assert property (@(posedge clock) disable iff (!reset_n)
    seq_first_i |-> seq_valid_i ##(`CORR_TRATE - 1) seq_last_i)
    else begin
      $error("frame markers not TRATE beats apart");
      fail_cnt++;
    end

  // Dump opens on slot 0, counts up, closes after the last slot
  a_dump_start: assert property (@(posedge clock) disable iff (!reset_n)
    $rose(vis_valid_i) |-> vis_slot_i == '0)
    else begin
      $error("dump did not start on slot 0");
      fail_cnt++;
    end

  a_dump_step: assert property (@(posedge clock) disable iff (!reset_n)
    vis_valid_i && vis_slot_i != LAST_SLOT |=>
      vis_valid_i && vis_slot_i == slot_t'($past(vis_slot_i) + 1'b1))
    else begin
      $error("dump slots not consecutive");
      fail_cnt++;
    end

  a_dump_end: assert property (@(posedge clock) disable iff (!reset_n)
    vis_valid_i && vis_slot_i == LAST_SLOT |=> !vis_valid_i)
    else begin
      $error("dump longer than TRATE slots");
      fail_cnt++;
    end

endmodule

bind correlator_top correlator_assertions u_checks (
  .clock          (clock),
  .reset_n        (reset_n),
  .sample_valid_i (sample_valid_i),
  .seq_valid_i    (seq_valid),
  .seq_first_i    (seq_first),
  .seq_last_i     (seq_last),
  .vis_valid_i    (vis_valid_o),
  .vis_slot_i     (vis_slot_o)
);

// File: tests/correlator_tb.sv
`timescale 1ns/10ps
`include "corr_consts.svh"

module correlator_tb;
  import corr_pkg::*;

  localparam int TRATE        = `CORR_TRATE;
  localparam int FRAMES       = `CORR_ACC_FRAMES;
  localparam int RESET_CYCLES = 16;
  localparam int DUMP_LATENCY = 10;  // Final strobe to first vis_valid_o
  localparam int N_TESTS      = 6;

  // Antenna pair correlated in each slot
  localparam int PAIR_A [TRATE] = '{0, 0, 1, 1, 2, 3};
  localparam int PAIR_B [TRATE] = '{4, 5, 5, 6, 7, 7};

  typedef enum {MODE_RANDOM, MODE_CONST, MODE_ALT} sample_mode_t;

  typedef struct {
    string        name;
    int           n_int;  // Integrations
    sample_mode_t mode;
    antenna_t     ci;
    antenna_t     cq;
    int           gap;    // Strobe spacing in cycles (TRATE+1 or more)
  } test_row_t;

  logic     clock;
  logic     reset_n;
  logic     sample_valid_i;
  antenna_t sample_i_i;
  antenna_t sample_q_i;
  logic     vis_valid_o;
  slot_t    vis_slot_o;
  vis_t     vis_re_o;
  vis_t     vis_im_o;

  test_row_t   table_rows [N_TESTS];
  logic [15:0] lfsr_state;
  int          model_re [TRATE];  // Running sums of the open integration
  int          model_im [TRATE];
  int          checks;
  int          errors;

  correlator_top dut_i (.*);

  always #20 clock = ~clock;

  task automatic load_table();
    table_rows[0] = '{"all_ones",      1, MODE_CONST,  8'hFF, 8'hFF, 7};
    table_rows[1] = '{"split_sign",    1, MODE_CONST,  8'h0F, 8'h0F, 7};
    table_rows[2] = '{"a_iq_quad",     1, MODE_CONST,  8'h0F, 8'h00, 8};  // Imag sign rule
    table_rows[3] = '{"random_pairs",  2, MODE_RANDOM, 8'h00, 8'h00, 9};
    table_rows[4] = '{"back_to_back",  3, MODE_ALT,    8'h5A, 8'hC3, 7};  // Minimum gap
    table_rows[5] = '{"reset_latency", 1, MODE_RANDOM, 8'h00, 8'h00, 12};
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(output antenna_t v);
    for (int b = 0; b < `CORR_WIDTH; b++) begin
      lfsr_state = lfsr_step(lfsr_state);  // One step per bit
      v[b] = lfsr_state[0];
    end
  endtask

  function automatic int sign_value(input logic b);
    return b ? 1 : -1;
  endfunction

  // Reference product A*conj(B) for every slot of one sample
  task automatic accumulate_sample(input antenna_t si, input antenna_t sq);
    int ai;
    int aq;
    int bi;
    int bq;
    for (int t = 0; t < TRATE; t++) begin
      ai = sign_value(si[PAIR_A[t]]);
      aq = sign_value(sq[PAIR_A[t]]);
      bi = sign_value(si[PAIR_B[t]]);
      bq = sign_value(sq[PAIR_B[t]]);
      model_re[t] += ai * bi + aq * bq;
      model_im[t] += aq * bi - ai * bq;
    end
  endtask

  task automatic pick_sample(input test_row_t row, input int n,
                             output antenna_t si, output antenna_t sq);
    case (row.mode)
      MODE_RANDOM: begin
        draw_bits(si);
        draw_bits(sq);
      end
      MODE_CONST: begin
        si = row.ci;
        sq = row.cq;
      end
      default: begin
        si = n[0] ? ~row.ci : row.ci;  // Flip every other sample
        sq = n[0] ? ~row.cq : row.cq;
      end
    endcase
  endtask

  task automatic check_slot(input string name, input slot_t exp, input slot_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: vis_slot expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_vis(input string name, input string what,
                           input vis_t exp, input vis_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: %s expected %0d actual %0d", name, what, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("Fail %s: dump latency expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset_n        <= 1'b0;
    sample_valid_i <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset_n <= 1'b1;
  endtask

  task automatic run_test(input int idx);
    test_row_t row;
    antenna_t  si;
    antenna_t  sq;
    int        cyc;
    int        sent;
    int        total;
    int        next_strobe;
    int        got;
    int        beat;
    int        limit;
    int        launch;
    bit        in_dump;
    int        launch_q [$];  // Cycle of each integration's final strobe
    int        exp_re_q [$];  // TRATE entries per integration
    int        exp_im_q [$];
    int        cur_re [TRATE];
    int        cur_im [TRATE];
    int        err_start;
    int        chk_start;
    row       = table_rows[idx];
    err_start = errors;
    chk_start = checks;
    apply_reset();
    for (int t = 0; t < TRATE; t++) begin
      model_re[t] = 0;
      model_im[t] = 0;
    end
    cyc         = 0;
    sent        = 0;
    got         = 0;
    beat        = 0;
    in_dump     = 1'b0;
    next_strobe = 1;
    total       = row.n_int * FRAMES;
    limit       = total * row.gap + 4 * DUMP_LATENCY;  // Timeout
    while (got < row.n_int && cyc < limit) begin
      @(posedge clock);
      cyc++;
      if (sent < total && cyc == next_strobe) begin
        pick_sample(row, sent, si, sq);
        sample_valid_i <= 1'b1;
        sample_i_i     <= si;
        sample_q_i     <= sq;
        accumulate_sample(si, sq);
        sent++;
        next_strobe = cyc + row.gap;
        if (sent % FRAMES == 0) begin  // Integration closes on this sample
          launch_q.push_back(cyc);
          for (int t = 0; t < TRATE; t++) begin
            exp_re_q.push_back(model_re[t]);
            exp_im_q.push_back(model_im[t]);
            model_re[t] = 0;
            model_im[t] = 0;
          end
        end
      end else begin
        sample_valid_i <= 1'b0;
      end
      @(negedge clock);  // Outputs settled
      if (vis_valid_o && !in_dump) begin
        if (launch_q.size() == 0) begin
          errors++;
          $display("Error in %s: vis_valid_o high before an integration completed",
                   row.name);
        end else begin
          launch = launch_q.pop_front();
          check_latency(row.name, DUMP_LATENCY, cyc - launch);
          for (int t = 0; t < TRATE; t++) begin
            cur_re[t] = exp_re_q.pop_front();
            cur_im[t] = exp_im_q.pop_front();
          end
          in_dump = 1'b1;
          beat    = 0;
        end
      end
      if (in_dump) begin
        if (!vis_valid_o) begin
          errors++;
          $display("Error in %s: dump stopped after %0d of %0d slots", row.name, beat, TRATE);
          in_dump = 1'b0;
          got++;
        end else begin
          check_slot(row.name, slot_t'(beat), vis_slot_o);
          check_vis(row.name, $sformatf("slot %0d re", beat), vis_t'(cur_re[beat]), vis_re_o);
          check_vis(row.name, $sformatf("slot %0d im", beat), vis_t'(cur_im[beat]), vis_im_o);
          beat++;
          if (beat == TRATE) begin
            in_dump = 1'b0;
            got++;
          end
        end
      end
    end
    if (got < row.n_int) begin
      errors++;
      $display("Timeout in %s: only %0d of %0d dumps arrived", row.name, got, row.n_int);
    end
    $display("%s: %0d checks, %0d errors", row.name, checks - chk_start, errors - err_start);
  endtask

  initial begin
    clock          = 1'b0;
    reset_n        = 1'b0;
    sample_valid_i = 1'b0;
    sample_i_i     = '0;
    sample_q_i     = '0;
    lfsr_state     = 16'd69;
    checks         = 0;
    errors         = 0;
    load_table();
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(i);
    end
    if (dut_i.u_checks.fail_cnt != 0) begin
      errors += dut_i.u_checks.fail_cnt;
      $display("Protocol assertions failed %0d times", dut_i.u_checks.fail_cnt);
    end
    $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/corr_pkg.sv
logic/slot_sequencer.sv
logic/sigsource.sv
logic/baseline_correlator.sv
logic/correlator_top.sv
tests/correlator_assertions.sv
tests/correlator_tb.sv
